// File: hdl/vga_defines.svh
// Video timing, overlay geometry and colours for the 800x600 text overlay
// Sync pulses are active high; counts start at zero on the first active pixel
// PIPE_LATENCY must track the register stages from counter to output

`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

// Horizontal timing in pixels
`define H_ACTIVE        800
`define H_SYNC_START    840
`define H_SYNC_END      968
`define H_TOTAL         1056

// Vertical timing in lines
`define V_ACTIVE        600
`define V_SYNC_START    601
`define V_SYNC_END      605
`define V_TOTAL         628

// Text rectangle, 16 cells of 8x16 pixels in each direction
`define RECT_XPOS       64
`define RECT_YPOS       40
`define RECT_WIDTH      128
`define RECT_HEIGHT     256

`define COLOR_FILL      12'h8_a_c
`define COLOR_BORDER    12'hf_0_0
`define COLOR_TEXT_ON   12'hf_f_f
`define COLOR_TEXT_OFF  12'h0_0_0

// Cycles from counter value to pixel at the top-level outputs
`define PIPE_LATENCY    5

`endif

// File: hdl/vga_pkg.sv
// Shared types for the text overlay pipeline
// Cell addresses assume a 16x16 grid of cells, row major

`default_nettype none

package vga_pkg;

        // Horizontal and vertical screen counters
        typedef logic [11:0] coord_t;

        // 4 bits each of red, green, blue
        typedef logic [11:0] rgb_t;

        // Row times 16 plus column
        typedef logic [7:0] cell_addr_t;

        typedef logic [7:0] char_code_t;

        // Line within a 16-line glyph
        typedef logic [3:0] glyph_line_t;

        // Bit 7 is the leftmost pixel of the row
        typedef logic [7:0] pixel_row_t;

endpackage

`default_nettype wire

// File: hdl/vga_timing.sv
// Free-running 800x600 timing generator, one pixel per pclk
// Sync and blank are decoded from the next counter values so that
// all six outputs change on the same edge

`timescale 1ns/1ns
`default_nettype none
`include "vga_defines.svh"

module vga_timing (
        input  wire              pclk,
        input  wire              rst,
        output vga_pkg::coord_t  hcount,
        output vga_pkg::coord_t  vcount,
        output logic             hsync,
        output logic             vsync,
        output logic             hblnk,
        output logic             vblnk
);

        import vga_pkg::*;

        coord_t hcount_nxt;
        coord_t vcount_nxt;
        logic   line_end;
        logic   frame_end;

        always_comb begin
                line_end  = (hcount == coord_t'(`H_TOTAL - 1));
                frame_end = (vcount == coord_t'(`V_TOTAL - 1));

                if (line_end) begin
                        hcount_nxt = '0;
                end else begin
                        hcount_nxt = hcount + 1'b1;
                end

                // Vertical count only advances at the end of a line
                vcount_nxt = vcount;
                if (line_end) begin
                        if (frame_end) begin
                                vcount_nxt = '0;
                        end else begin
                                vcount_nxt = vcount + 1'b1;
                        end
                end
        end

        always_ff @(posedge pclk) begin
                if (rst) begin
                        hcount <= '0;
                        vcount <= '0;
                        hsync  <= 1'b0;
                        vsync  <= 1'b0;
                        hblnk  <= 1'b0;
                        vblnk  <= 1'b0;
                end else begin
                        hcount <= hcount_nxt;
                        vcount <= vcount_nxt;
                        hsync  <= (hcount_nxt >= coord_t'(`H_SYNC_START)) &&
                                  (hcount_nxt <  coord_t'(`H_SYNC_END));
                        vsync  <= (vcount_nxt >= coord_t'(`V_SYNC_START)) &&
                                  (vcount_nxt <  coord_t'(`V_SYNC_END));
                        hblnk  <= (hcount_nxt >= coord_t'(`H_ACTIVE));
                        vblnk  <= (vcount_nxt >= coord_t'(`V_ACTIVE));
                end
        end

endmodule

`default_nettype wire

// File: hdl/draw_background.sv
// Background painter, one register stage on the whole timing stream
// Red frame on the outermost active pixels, fill colour inside, black in blanking

`timescale 1ns/1ns
`default_nettype none
`include "vga_defines.svh"

module draw_background (
        input  wire              pclk,
        input  wire              rst,
        input  vga_pkg::coord_t  hcount_in,
        input  vga_pkg::coord_t  vcount_in,
        input  wire              hsync_in,
        input  wire              vsync_in,
        input  wire              hblnk_in,
        input  wire              vblnk_in,
        output vga_pkg::coord_t  hcount_out,
        output vga_pkg::coord_t  vcount_out,
        output logic             hsync_out,
        output logic             vsync_out,
        output logic             hblnk_out,
        output logic             vblnk_out,
        output vga_pkg::rgb_t    rgb_out
);

        import vga_pkg::*;

        rgb_t rgb_nxt;
        logic on_edge;

        always_comb begin
                on_edge = (hcount_in == '0) || (hcount_in == coord_t'(`H_ACTIVE - 1)) ||
                          (vcount_in == '0) || (vcount_in == coord_t'(`V_ACTIVE - 1));

                if (hblnk_in || vblnk_in) begin
                        rgb_nxt = '0;
                end else if (on_edge) begin
                        rgb_nxt = `COLOR_BORDER;
                end else begin
                        rgb_nxt = `COLOR_FILL;
                end
        end

        always_ff @(posedge pclk) begin
                if (rst) begin
                        hcount_out <= '0;
                        vcount_out <= '0;
                        hsync_out  <= 1'b0;
                        vsync_out  <= 1'b0;
                        hblnk_out  <= 1'b0;
                        vblnk_out  <= 1'b0;
                        rgb_out    <= '0;
                end else begin
                        hcount_out <= hcount_in;
                        vcount_out <= vcount_in;
                        hsync_out  <= hsync_in;
                        vsync_out  <= vsync_in;
                        hblnk_out  <= hblnk_in;
                        vblnk_out  <= vblnk_in;
                        rgb_out    <= rgb_nxt;
                end
        end

endmodule

`default_nettype wire

// File: hdl/signal_delay.sv
// Shift-register delay of CLK_DEL cycles, cleared to zero by reset
// CLK_DEL of 0 gives a plain combinational path

`timescale 1ns/1ns
`default_nettype none

module signal_delay #(
        parameter int WIDTH   = 8,
        parameter int CLK_DEL = 1
) (
        input  wire              pclk,
        input  wire              rst,
        input  wire  [WIDTH-1:0] din,
        output logic [WIDTH-1:0] dout
);

        if (CLK_DEL == 0) begin : g_pass
                assign dout = din;
        end else begin : g_shift
                logic [WIDTH-1:0] stage [CLK_DEL];

                always_ff @(posedge pclk) begin
                        if (rst) begin
                                for (int i = 0; i < CLK_DEL; i++) begin
                                        stage[i] <= '0;
                                end
                        end else begin
                                stage[0] <= din;
                                for (int i = 1; i < CLK_DEL; i++) begin
                                        stage[i] <= stage[i-1];
                                end
                        end
                end

                assign dout = stage[CLK_DEL-1];
        end

endmodule

`default_nettype wire

// File: hdl/char_map.sv
// 256-cell text buffer, one write port and one registered read port
// Contents are not initialised; read during a write to the same cell
// returns the old code

`timescale 1ns/1ns
`default_nettype none

module char_map (
        input  wire                  pclk,
        input  vga_pkg::cell_addr_t  text_xy,
        input  wire                  wr_en,
        input  vga_pkg::cell_addr_t  wr_addr,
        input  vga_pkg::char_code_t  wr_char,
        output vga_pkg::char_code_t  char_code
);

        import vga_pkg::*;

        localparam int CELLS = 2 ** $bits(cell_addr_t);

        char_code_t mem [CELLS];

        // Write port
        always_ff @(posedge pclk) begin
                if (wr_en) begin
                        mem[wr_addr] <= wr_char;
                end
        end

        // Read port, kept as a separate process for block RAM inference
        always_ff @(posedge pclk) begin
                char_code <= mem[text_xy];
        end

endmodule

`default_nettype wire

// File: hdl/block_glyph_rom.sv
// Block-graphics font in place of a bitmap ROM, one cycle of latency
// Each glyph is eight bars of 2 lines; code bit 0 is the top bar
// A set bit lights the whole 8-pixel row, a clear bit leaves it dark

`timescale 1ns/1ns
`default_nettype none

module block_glyph_rom (
        input  wire                   pclk,
        input  wire                   rst,
        input  vga_pkg::char_code_t   char_code,
        input  vga_pkg::glyph_line_t  text_line,
        output vga_pkg::pixel_row_t   char_pixel
);

        import vga_pkg::*;

        logic [2:0]  bar_sel;
        pixel_row_t  row_nxt;

        always_comb begin
                // Two glyph lines per bar
                bar_sel = text_line[3:1];

                if (char_code[bar_sel]) begin
                        row_nxt = '1;
                end else begin
                        row_nxt = '0;
                end
        end

        always_ff @(posedge pclk) begin
                if (rst) begin
                        char_pixel <= '0;
                end else begin
                        char_pixel <= row_nxt;
                end
        end

endmodule

`default_nettype wire

// File: hdl/draw_rect_char.sv
// Text overlay in a fixed 128x256 rectangle of 16x16 cells, 8x16 pixels each
// Cell address and glyph line leave one cycle after the stream enters;
// the glyph row must come back two cycles after that
// The stream is delayed three cycles to match, then the mix is registered

`timescale 1ns/1ns
`default_nettype none
`include "vga_defines.svh"

module draw_rect_char (
        input  wire                   pclk,
        input  wire                   rst,
        input  vga_pkg::coord_t       hcount_in,
        input  vga_pkg::coord_t       vcount_in,
        input  wire                   hsync_in,
        input  wire                   vsync_in,
        input  wire                   hblnk_in,
        input  wire                   vblnk_in,
        input  vga_pkg::rgb_t         rgb_in,
        input  vga_pkg::pixel_row_t   char_pixel,
        output logic                  hsync_out,
        output logic                  vsync_out,
        output vga_pkg::rgb_t         rgb_out,
        output vga_pkg::cell_addr_t   text_xy,
        output vga_pkg::glyph_line_t  text_line
);

        import vga_pkg::*;

        // Syncs, blank, colour, hcount, vertical hit and pixel select
        localparam int DEL_WIDTH  = 31;
        localparam int DEL_CYCLES = 3;

        coord_t     x_off;
        coord_t     y_off;
        logic       in_rect_y;
        logic       hsync_d;
        logic       vsync_d;
        logic       blank_d;
        rgb_t       rgb_d;
        coord_t     hcount_d;
        logic       in_rect_y_d;
        logic [2:0] x_sel_d;
        logic       in_rect_d;
        rgb_t       rgb_nxt;

        // Position relative to the rectangle's top left corner
        always_comb begin
                x_off     = hcount_in - coord_t'(`RECT_XPOS);
                y_off     = vcount_in - coord_t'(`RECT_YPOS);
                in_rect_y = (vcount_in >= coord_t'(`RECT_YPOS)) &&
                            (vcount_in <  coord_t'(`RECT_YPOS + `RECT_HEIGHT));
        end

        signal_delay #(
                .WIDTH   (DEL_WIDTH),
                .CLK_DEL (DEL_CYCLES)
        ) i_stream_delay (
                .pclk (pclk),
                .rst  (rst),
                .din  ({hsync_in, vsync_in, hblnk_in | vblnk_in, rgb_in,
                        hcount_in, in_rect_y, x_off[2:0]}),
                .dout ({hsync_d, vsync_d, blank_d, rgb_d,
                        hcount_d, in_rect_y_d, x_sel_d})
        );

        always_comb begin
                in_rect_d = in_rect_y_d &&
                            (hcount_d >= coord_t'(`RECT_XPOS)) &&
                            (hcount_d <  coord_t'(`RECT_XPOS + `RECT_WIDTH));

                if (blank_d || !in_rect_d) begin
                        rgb_nxt = rgb_d;
                end else if (char_pixel[3'd7 - x_sel_d]) begin
                        rgb_nxt = `COLOR_TEXT_ON;
                end else begin
                        rgb_nxt = `COLOR_TEXT_OFF;
                end
        end

        always_ff @(posedge pclk) begin
                if (rst) begin
                        hsync_out <= 1'b0;
                        vsync_out <= 1'b0;
                        rgb_out   <= '0;
                        text_xy   <= '0;
                        text_line <= '0;
                end else begin
                        hsync_out <= hsync_d;
                        vsync_out <= vsync_d;
                        rgb_out   <= rgb_nxt;
                        // Cell row in the high nibble, cell column in the low
                        text_xy   <= {y_off[7:4], x_off[6:3]};
                        text_line <= y_off[3:0];
                end
        end

endmodule

`default_nettype wire

// File: hdl/vga_text_top.sv
// SVGA 800x600 text overlay, pclk is the 40 MHz pixel clock
// Output latency is PIPE_LATENCY cycles from the timing counters
// Text buffer is not cleared by reset; write cells before showing them

`timescale 1ns/1ns
`default_nettype none

module vga_text_top (
        input  wire                  pclk,
        input  wire                  rst,
        input  wire                  wr_en,
        input  vga_pkg::cell_addr_t  wr_addr,
        input  vga_pkg::char_code_t  wr_char,
        output logic                 hsync,
        output logic                 vsync,
        output vga_pkg::rgb_t        rgb
);

        import vga_pkg::*;

        // Timing generator outputs
        coord_t      tim_hcount;
        coord_t      tim_vcount;
        logic        tim_hsync;
        logic        tim_vsync;
        logic        tim_hblnk;
        logic        tim_vblnk;

        // Background stream
        coord_t      bg_hcount;
        coord_t      bg_vcount;
        logic        bg_hsync;
        logic        bg_vsync;
        logic        bg_hblnk;
        logic        bg_vblnk;
        rgb_t        bg_rgb;

        // Character path
        cell_addr_t  text_xy;
        glyph_line_t text_line;
        char_code_t  char_code;
        pixel_row_t  char_pixel;

        vga_timing i_vga_timing (
                .pclk   (pclk),
                .rst    (rst),
                .hcount (tim_hcount),
                .vcount (tim_vcount),
                .hsync  (tim_hsync),
                .vsync  (tim_vsync),
                .hblnk  (tim_hblnk),
                .vblnk  (tim_vblnk)
        );

        draw_background i_draw_background (
                .pclk       (pclk),
                .rst        (rst),
                .hcount_in  (tim_hcount),
                .vcount_in  (tim_vcount),
                .hsync_in   (tim_hsync),
                .vsync_in   (tim_vsync),
                .hblnk_in   (tim_hblnk),
                .vblnk_in   (tim_vblnk),
                .hcount_out (bg_hcount),
                .vcount_out (bg_vcount),
                .hsync_out  (bg_hsync),
                .vsync_out  (bg_vsync),
                .hblnk_out  (bg_hblnk),
                .vblnk_out  (bg_vblnk),
                .rgb_out    (bg_rgb)
        );

        draw_rect_char i_draw_rect_char (
                .pclk       (pclk),
                .rst        (rst),
                .hcount_in  (bg_hcount),
                .vcount_in  (bg_vcount),
                .hsync_in   (bg_hsync),
                .vsync_in   (bg_vsync),
                .hblnk_in   (bg_hblnk),
                .vblnk_in   (bg_vblnk),
                .rgb_in     (bg_rgb),
                .char_pixel (char_pixel),
                .hsync_out  (hsync),
                .vsync_out  (vsync),
                .rgb_out    (rgb),
                .text_xy    (text_xy),
                .text_line  (text_line)
        );

        char_map i_char_map (
                .pclk      (pclk),
                .text_xy   (text_xy),
                .wr_en     (wr_en),
                .wr_addr   (wr_addr),
                .wr_char   (wr_char),
                .char_code (char_code)
        );

        block_glyph_rom i_block_glyph_rom (
                .pclk       (pclk),
                .rst        (rst),
                .char_code  (char_code),
                .text_line  (text_line),
                .char_pixel (char_pixel)
        );

endmodule

`default_nettype wire

// File: verif/clk_gen.sv
// Testbench clock and reset source
// Reset is held high for RST_CYCLES rising edges, then released 2 ns after an edge

`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
        parameter int PERIOD_NS  = 40,
        parameter int RST_CYCLES = 2
) (
        output logic clk,
        output logic rst
);

        initial begin
                clk = 1'b0;
                forever #(PERIOD_NS / 2) clk = ~clk;
        end

        initial begin
                rst = 1'b1;
                repeat (RST_CYCLES) @(posedge clk);
                #2 rst = 1'b0;
        end

endmodule

`default_nettype wire

// File: verif/tb_vga_text.sv
// Directed tests for the 800x600 text overlay top level
// Screen position is recovered from the output syncs; checks start once both are seen
// The run covers under seven frames and a watchdog bounds it

`timescale 1ns/1ns
`default_nettype none
`include "vga_defines.svh"

module tb_vga_text;

        import vga_pkg::*;

        localparam longint FRAME_NS    = 64'd1056 * 64'd628 * 64'd40;
        localparam longint TEST_FRAMES = 7;

        logic        pclk;
        logic        rst;
        logic        wr_en;
        cell_addr_t  wr_addr;
        char_code_t  wr_char;
        logic        hsync;
        logic        vsync;
        rgb_t        rgb;

        char_code_t  shadow [256];
        int          errors;
        int          h_pos;
        int          v_pos;
        logic        locked;
        logic        hs_prev;
        logic        vs_prev;

        clk_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) i_clk_gen (.clk(pclk), .rst(rst));

        vga_text_top i_dut (
                .pclk    (pclk),
                .rst     (rst),
                .wr_en   (wr_en),
                .wr_addr (wr_addr),
                .wr_char (wr_char),
                .hsync   (hsync),
                .vsync   (vsync),
                .rgb     (rgb)
        );

        // Position tracker, updated just after each edge once outputs settle
        always @(posedge pclk) begin
                #1;
                if (hsync && !hs_prev) begin
                        h_pos = `H_SYNC_START;
                end else begin
                        h_pos = (h_pos + 1) % `H_TOTAL;
                end
                if (h_pos == 0) begin
                        v_pos = (v_pos + 1) % `V_TOTAL;
                end
                if (vsync && !vs_prev) begin
                        v_pos  = `V_SYNC_START;
                        locked = 1'b1;
                end
                hs_prev = hsync;
                vs_prev = vsync;
        end

        function automatic rgb_t expected_rgb(input int h, input int v);
                char_code_t code;
                int         line;
                if (h >= `H_ACTIVE || v >= `V_ACTIVE) begin
                        return 12'h000;
                end
                if (h >= `RECT_XPOS && h < `RECT_XPOS + `RECT_WIDTH &&
                    v >= `RECT_YPOS && v < `RECT_YPOS + `RECT_HEIGHT) begin
                        code = shadow[((v - `RECT_YPOS) / 16) * 16 + (h - `RECT_XPOS) / 8];
                        line = (v - `RECT_YPOS) % 16;
                        return code[line / 2] ? `COLOR_TEXT_ON : `COLOR_TEXT_OFF;
                end
                if (h == 0 || h == `H_ACTIVE - 1 || v == 0 || v == `V_ACTIVE - 1) begin
                        return `COLOR_BORDER;
                end
                return `COLOR_FILL;
        endfunction

        task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
                if (got !== exp) begin
                        errors++;
                        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
                end
        endtask

        task automatic check_sync(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        errors++;
                        $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
                end
        endtask

        task automatic check_count(input string name, input int got, input int exp);
                if (got != exp) begin
                        errors++;
                        $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
                end
        endtask

        task automatic wait_pos(input int hp, input int vp);
                while (!(locked && h_pos == hp && v_pos == vp)) @(negedge pclk);
        endtask

        // Checks every pixel of the given lines, in one frame
        task automatic scan_lines(input int first, input int last, input int step);
                for (int v = first; v <= last; v += step) begin
                        wait_pos(0, v);
                        for (int h = 0; h < `H_TOTAL; h++) begin
                                check_rgb("rgb", rgb, expected_rgb(h_pos, v_pos));
                                @(negedge pclk);
                        end
                end
        endtask

        task automatic write_cell(input cell_addr_t addr, input char_code_t code);
                @(posedge pclk);
                #2;
                wr_en   = 1'b1;
                wr_addr = addr;
                wr_char = code;
                shadow[addr] = code;
                @(posedge pclk);
                #2;
                wr_en = 1'b0;
        endtask

        // Cycles of the high pulse and from one rising edge to the next
        task automatic measure_pulse(input bit use_v, output int width, output int period);
                @(negedge pclk);
                while ((use_v ? vsync : hsync) !== 1'b0) @(negedge pclk);
                while ((use_v ? vsync : hsync) !== 1'b1) @(negedge pclk);
                width  = 0;
                period = 0;
                while ((use_v ? vsync : hsync) === 1'b1) begin
                        width++;
                        period++;
                        @(negedge pclk);
                end
                while ((use_v ? vsync : hsync) === 1'b0) begin
                        period++;
                        @(negedge pclk);
                end
        endtask

        task automatic test_reset_outputs();
                @(posedge pclk);
                @(negedge pclk);
                while (rst) begin
                        check_sync("hsync", hsync, 1'b0);
                        check_sync("vsync", vsync, 1'b0);
                        check_rgb("rgb", rgb, 12'h000);
                        @(negedge pclk);
                end
                repeat (3) begin
                        check_sync("hsync", hsync, 1'b0);
                        check_sync("vsync", vsync, 1'b0);
                        check_rgb("rgb", rgb, 12'h000);
                        @(negedge pclk);
                end
        endtask

        task automatic test_hsync_timing();
                int width;
                int period;
                measure_pulse(1'b0, width, period);
                check_count("hsync width", width, `H_SYNC_END - `H_SYNC_START);
                check_count("hsync period", period, `H_TOTAL);
        endtask

        task automatic test_vsync_timing();
                int width;
                int period;
                measure_pulse(1'b1, width, period);
                check_count("vsync width", width, 4 * `H_TOTAL);
                check_count("vsync period", period, `V_TOTAL * `H_TOTAL);
        endtask

        task automatic fill_all_cells();
                for (int i = 0; i < 256; i++) begin
                        write_cell(cell_addr_t'(i), char_code_t'($urandom));
                end
        endtask

        task automatic test_background();
                scan_lines(0, 1, 1);
                scan_lines(20, 20, 1);
                scan_lines(599, 600, 1);
                scan_lines(615, 615, 1);
        endtask

        task automatic test_char_writes();
                scan_lines(`RECT_YPOS, `RECT_YPOS + `RECT_HEIGHT - 1, 5);
        endtask

        task automatic test_corner_cells();
                // Writes land in vertical blanking, the next frame shows them
                wait_pos(0, 605);
                write_cell(8'd0, 8'h01);
                write_cell(8'd15, 8'h03);
                write_cell(8'd240, 8'h80);
                write_cell(8'd255, 8'hc0);
                scan_lines(`RECT_YPOS - 1, `RECT_YPOS + 1, 1);
                scan_lines(`RECT_YPOS + `RECT_HEIGHT - 2, `RECT_YPOS + `RECT_HEIGHT, 1);
        endtask

        task automatic test_rewrite();
                char_code_t old_code;
                old_code = shadow[8'h53];
                // Row 5 is on lines 120 to 135, rewrite it while it is drawn
                wait_pos(0, 128);
                write_cell(8'h53, ~old_code);
                scan_lines(120, 135, 1);
        endtask

        initial begin
                wr_en   = 1'b0;
                wr_addr = '0;
                wr_char = '0;
                errors  = 0;
                h_pos   = 0;
                v_pos   = 0;
                locked  = 1'b0;
                hs_prev = 1'b0;
                vs_prev = 1'b0;
                void'($urandom(41764));
                foreach (shadow[i]) shadow[i] = '0;

                test_reset_outputs();
                test_hsync_timing();
                fill_all_cells();
                test_vsync_timing();
                test_background();
                test_char_writes();
                test_corner_cells();
                test_rewrite();

                $display("Errors: %0d", errors);
                if (errors == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end

        // Watchdog, one frame of margin over the tests
        initial begin
                #((TEST_FRAMES + 1) * FRAME_NS);
                $display("Watchdog expired before the tests finished, errors: %0d", errors);
                $display("TESTBENCH FAILED");
                $finish;
        end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hdl
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/draw_background.sv
hdl/signal_delay.sv
hdl/char_map.sv
hdl/block_glyph_rom.sv
hdl/draw_rect_char.sv
hdl/vga_text_top.sv
verif/clk_gen.sv
verif/tb_vga_text.sv

// File: Bender.yml
package:
  name: vga_text_overlay

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vga_pkg.sv
      - hdl/vga_timing.sv
      - hdl/draw_background.sv
      - hdl/signal_delay.sv
      - hdl/char_map.sv
      - hdl/block_glyph_rom.sv
      - hdl/draw_rect_char.sv
      - hdl/vga_text_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/clk_gen.sv
      - verif/tb_vga_text.sv
